// File: Makefile
TOP = tb_dcache_mem

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: common/bank_if.sv
`timescale 1ns/1ps

interface bank_if;

  // request and write side, one entry per bank
  logic [dcache_pkg::num_banks-1:0] bank_req;
  logic [dcache_pkg::num_banks-1:0] bank_we;
  dcache_pkg::idx_t [dcache_pkg::num_banks-1:0] bank_idx;
  dcache_pkg::be_t [dcache_pkg::num_banks-1:0][dcache_pkg::num_ways-1:0] bank_be;
  dcache_pkg::word_t [dcache_pkg::num_banks-1:0][dcache_pkg::num_ways-1:0] bank_wdata;

  // read side, every way of a bank comes out together
  dcache_pkg::word_t [dcache_pkg::num_banks-1:0][dcache_pkg::num_ways-1:0] bank_rdata;

  modport ctrl (output bank_req, bank_we, bank_idx, bank_be, bank_wdata);

  modport array (
    input  bank_req, bank_we, bank_idx, bank_be, bank_wdata,
    output bank_rdata
  );

  modport rd (input bank_rdata);

endinterface

// File: common/dcache_pkg.sv
package dcache_pkg;

  // cache geometry
  localparam int unsigned word_width = 32;
  localparam int unsigned num_ways   = 2;
  localparam int unsigned num_banks  = 4;
  localparam int unsigned num_sets   = 16;
  localparam int unsigned tag_width  = 8;

  // derived widths
  localparam int unsigned byte_sel_width = $clog2(word_width / 8);
  localparam int unsigned bank_sel_width = $clog2(num_banks);
  localparam int unsigned off_width      = bank_sel_width + byte_sel_width;
  localparam int unsigned idx_width      = $clog2(num_sets);
  localparam int unsigned line_width     = word_width * num_banks;

  typedef logic [word_width-1:0]     word_t;
  typedef logic [word_width/8-1:0]   be_t;
  // word k of a line sits at bits k*word_width upward
  typedef logic [line_width-1:0]     line_t;
  typedef logic [line_width/8-1:0]   line_be_t;
  typedef logic [tag_width-1:0]      tag_t;
  typedef logic [idx_width-1:0]      idx_t;
  // upper bits pick the bank, lower bits the byte
  typedef logic [off_width-1:0]      off_t;
  typedef logic [bank_sel_width-1:0] bank_sel_t;
  typedef logic [num_ways-1:0]       way_vec_t;

  // index width for n ports, at least one bit
  function automatic int unsigned sel_bits(int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// File: common/tag_if.sv
`timescale 1ns/1ps

interface tag_if;

  // one request bit per way, shared address
  dcache_pkg::way_vec_t tag_req;
  logic                 tag_we;
  dcache_pkg::idx_t     tag_addr;
  dcache_pkg::tag_t     tag_wtag;
  dcache_pkg::way_vec_t tag_wvld;

  // stored tag and valid bit of every way
  dcache_pkg::tag_t [dcache_pkg::num_ways-1:0] tag_rdata;
  dcache_pkg::way_vec_t                        vld_rdata;

  modport ctrl (output tag_req, tag_we, tag_addr, tag_wtag, tag_wvld);
  modport array (input tag_req, tag_we, tag_addr, tag_wtag, tag_wvld, output tag_rdata, vld_rdata);
  modport rd (input tag_rdata, vld_rdata);

endinterface

// File: logic/bank_ctrl.sv
`timescale 1ns/1ps

module bank_ctrl #(
  parameter  int unsigned num_ports      = 3,
  localparam int unsigned port_idx_width = dcache_pkg::sel_bits(num_ports)
) (
  input  dcache_pkg::idx_t [num_ports-1:0] rd_idx_i,
  input  dcache_pkg::off_t [num_ports-1:0] rd_off_i,
  input  logic                             grant_valid_i,
  input  logic [port_idx_width-1:0]        grant_idx_i,
  input  logic                             wr_cl_vld_i,
  input  dcache_pkg::way_vec_t             wr_cl_we_i,
  input  dcache_pkg::tag_t                 wr_cl_tag_i,
  input  dcache_pkg::idx_t                 wr_cl_idx_i,
  input  dcache_pkg::line_t                wr_cl_data_i,
  input  dcache_pkg::line_be_t             wr_cl_be_i,
  input  dcache_pkg::way_vec_t             wr_vld_bits_i,
  input  dcache_pkg::way_vec_t             wr_req_i,
  input  dcache_pkg::idx_t                 wr_idx_i,
  input  dcache_pkg::off_t                 wr_off_i,
  input  dcache_pkg::word_t                wr_data_i,
  input  dcache_pkg::be_t                  wr_be_i,
  output logic                             wr_ack_o,
  output dcache_pkg::idx_t                 lookup_idx_o,
  output dcache_pkg::off_t                 lookup_off_o,
  output logic                             lookup_valid_o,
  bank_if.ctrl                             bank,
  tag_if.ctrl                              tags
);

  localparam int unsigned ww = dcache_pkg::word_width;
  localparam int unsigned bw = dcache_pkg::word_width / 8;

  dcache_pkg::bank_sel_t rd_bank;
  dcache_pkg::bank_sel_t wr_bank;

  assign rd_bank = rd_off_i[grant_idx_i][dcache_pkg::off_width-1:dcache_pkg::byte_sel_width];
  assign wr_bank = wr_off_i[dcache_pkg::off_width-1:dcache_pkg::byte_sel_width];

  // context of this cycle's array access
  assign lookup_idx_o   = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[grant_idx_i];
  assign lookup_off_o   = rd_off_i[grant_idx_i];
  assign lookup_valid_o = grant_valid_i & ~wr_cl_vld_i;

  // word write loses to a refill and to a read of the same bank
  assign wr_ack_o = (|wr_req_i) & ~wr_cl_vld_i & ~(grant_valid_i & (rd_bank == wr_bank));

  ////////////////////
  // tag array
  ////////////////////

  assign tags.tag_req  = wr_cl_vld_i ? wr_cl_we_i : {dcache_pkg::num_ways{grant_valid_i}};
  assign tags.tag_we   = wr_cl_vld_i;
  assign tags.tag_addr = lookup_idx_o;
  assign tags.tag_wtag = wr_cl_tag_i;
  assign tags.tag_wvld = wr_vld_bits_i;

  ////////////////////
  // data banks
  ////////////////////

  always_comb begin
    bank.bank_req = '0;
    bank.bank_we  = '0;
    for (int k = 0; k < dcache_pkg::num_banks; k++) begin
      bank.bank_idx[k] = wr_cl_vld_i ? wr_cl_idx_i : wr_idx_i;
      for (int w = 0; w < dcache_pkg::num_ways; w++) begin
        bank.bank_be[k][w]    = '0;
        bank.bank_wdata[k][w] = wr_cl_vld_i ? wr_cl_data_i[k*ww +: ww] : wr_data_i;
      end
    end

    if (wr_cl_vld_i) begin
      // refill writes its slice into every bank of the enabled ways
      bank.bank_req = '1;
      bank.bank_we  = '1;
      for (int k = 0; k < dcache_pkg::num_banks; k++) begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
          if (wr_cl_we_i[w]) begin
            bank.bank_be[k][w] = wr_cl_be_i[k*bw +: bw];
          end
        end
      end
    end else begin
      if (grant_valid_i) begin
        bank.bank_req[rd_bank] = 1'b1;
        bank.bank_idx[rd_bank] = rd_idx_i[grant_idx_i];
      end
      if (wr_ack_o) begin
        bank.bank_req[wr_bank] = 1'b1;
        bank.bank_we[wr_bank]  = 1'b1;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
          if (wr_req_i[w]) begin
            bank.bank_be[wr_bank][w] = wr_be_i;
          end
        end
      end
    end
  end

  // an acked word write targets a single way
  always_comb begin
    assert final (!wr_ack_o || $onehot0(wr_req_i));
  end

endmodule

// File: logic/dcache_mem.sv
`timescale 1ns/1ps

module dcache_mem #(
  parameter  int unsigned num_ports      = 3,
  localparam int unsigned port_idx_width = dcache_pkg::sel_bits(num_ports)
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // read ports
  input  dcache_pkg::tag_t [num_ports-1:0] rd_tag_i,
  input  dcache_pkg::idx_t [num_ports-1:0] rd_idx_i,
  input  dcache_pkg::off_t [num_ports-1:0] rd_off_i,
  input  logic [num_ports-1:0]             rd_req_i,
  input  logic [num_ports-1:0]             rd_prio_i,
  output logic [num_ports-1:0]             rd_ack_o,
  output dcache_pkg::way_vec_t             rd_vld_bits_o,
  output dcache_pkg::way_vec_t             rd_hit_oh_o,
  output dcache_pkg::word_t                rd_data_o,
  // line refill
  input  logic                             wr_cl_vld_i,
  input  dcache_pkg::way_vec_t             wr_cl_we_i,
  input  dcache_pkg::tag_t                 wr_cl_tag_i,
  input  dcache_pkg::idx_t                 wr_cl_idx_i,
  input  dcache_pkg::line_t                wr_cl_data_i,
  input  dcache_pkg::line_be_t             wr_cl_be_i,
  input  dcache_pkg::way_vec_t             wr_vld_bits_i,
  // single word write
  input  dcache_pkg::way_vec_t             wr_req_i,
  output logic                             wr_ack_o,
  input  dcache_pkg::idx_t                 wr_idx_i,
  input  dcache_pkg::off_t                 wr_off_i,
  input  dcache_pkg::word_t                wr_data_i,
  input  dcache_pkg::be_t                  wr_be_i
);

  logic                      grant_valid;
  logic [port_idx_width-1:0] grant_idx;
  dcache_pkg::off_t          lookup_off;
  logic                      lookup_valid;

  bank_if i_bank_if ();
  tag_if  i_tag_if ();

  read_arbiter #(
    .num_ports (num_ports)
  ) i_read_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .stall_i       (wr_cl_vld_i),
    .rd_ack_o      (rd_ack_o),
    .grant_valid_o (grant_valid),
    .grant_idx_o   (grant_idx)
  );

  bank_ctrl #(
    .num_ports (num_ports)
  ) i_bank_ctrl (
    .rd_idx_i       (rd_idx_i),
    .rd_off_i       (rd_off_i),
    .grant_valid_i  (grant_valid),
    .grant_idx_i    (grant_idx),
    .wr_cl_vld_i    (wr_cl_vld_i),
    .wr_cl_we_i     (wr_cl_we_i),
    .wr_cl_tag_i    (wr_cl_tag_i),
    .wr_cl_idx_i    (wr_cl_idx_i),
    .wr_cl_data_i   (wr_cl_data_i),
    .wr_cl_be_i     (wr_cl_be_i),
    .wr_vld_bits_i  (wr_vld_bits_i),
    .wr_req_i       (wr_req_i),
    .wr_idx_i       (wr_idx_i),
    .wr_off_i       (wr_off_i),
    .wr_data_i      (wr_data_i),
    .wr_be_i        (wr_be_i),
    .wr_ack_o       (wr_ack_o),
    .lookup_idx_o   (),
    .lookup_off_o   (lookup_off),
    .lookup_valid_o (lookup_valid),
    .bank           (i_bank_if.ctrl),
    .tags           (i_tag_if.ctrl)
  );

  hit_select #(
    .num_ports (num_ports)
  ) i_hit_select (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_tag_i       (rd_tag_i),
    .grant_idx_i    (grant_idx),
    .lookup_valid_i (lookup_valid),
    .lookup_off_i   (lookup_off),
    .bank           (i_bank_if.rd),
    .tags           (i_tag_if.rd),
    .rd_vld_bits_o  (rd_vld_bits_o),
    .rd_hit_oh_o    (rd_hit_oh_o),
    .rd_data_o      (rd_data_o)
  );

  data_banks i_data_banks (
    .clk_i (clk_i),
    .bank  (i_bank_if.array)
  );

  tag_array i_tag_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tags   (i_tag_if.array)
  );

endmodule

// File: logic/hit_select.sv
`timescale 1ns/1ps

module hit_select #(
  parameter  int unsigned num_ports      = 3,
  localparam int unsigned port_idx_width = dcache_pkg::sel_bits(num_ports)
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  dcache_pkg::tag_t [num_ports-1:0] rd_tag_i,
  input  logic [port_idx_width-1:0]        grant_idx_i,
  input  logic                             lookup_valid_i,
  input  dcache_pkg::off_t                 lookup_off_i,
  bank_if.rd                               bank,
  tag_if.rd                                tags,
  output dcache_pkg::way_vec_t             rd_vld_bits_o,
  output dcache_pkg::way_vec_t             rd_hit_oh_o,
  output dcache_pkg::word_t                rd_data_o
);

  logic [port_idx_width-1:0] sel_q;
  dcache_pkg::bank_sel_t     off_q;
  logic                      cmp_en_q;
  dcache_pkg::tag_t          rd_tag;

  // lookup context, aligned with the array read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= '0;
      off_q    <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      sel_q    <= grant_idx_i;
      off_q    <= lookup_off_i[dcache_pkg::off_width-1:dcache_pkg::byte_sel_width];
      cmp_en_q <= lookup_valid_i;
    end
  end

  // the port's tag arrives one cycle after its grant
  assign rd_tag        = rd_tag_i[sel_q];
  assign rd_vld_bits_o = tags.vld_rdata;

  for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = cmp_en_q & tags.vld_rdata[w] & (tags.tag_rdata[w] == rd_tag);
  end

  // way 0 unless another way hits
  always_comb begin
    rd_data_o = bank.bank_rdata[off_q][0];
    for (int w = 1; w < dcache_pkg::num_ways; w++) begin
      if (rd_hit_oh_o[w]) begin
        rd_data_o = bank.bank_rdata[off_q][w];
      end
    end
  end

  // a set never holds the same tag valid in two ways
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup_valid_i |=> $onehot0(rd_hit_oh_o));

endmodule

// File: logic/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter #(
  parameter  int unsigned num_ports      = 3,
  localparam int unsigned port_idx_width = dcache_pkg::sel_bits(num_ports)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [num_ports-1:0]      rd_req_i,
  input  logic [num_ports-1:0]      rd_prio_i,
  input  logic                      stall_i,
  output logic [num_ports-1:0]      rd_ack_o,
  output logic                      grant_valid_o,
  output logic [port_idx_width-1:0] grant_idx_o
);

  logic [num_ports-1:0]      req_prio;
  logic [num_ports-1:0]      req_masked;
  logic [port_idx_width-1:0] ptr_q;
  logic                      found;

  // port index base + k wrapped at num_ports
  function automatic logic [port_idx_width-1:0] wrap(logic [port_idx_width-1:0] base,
                                                     int unsigned k);
    int unsigned sum;
    sum = base + k;
    if (sum >= num_ports) begin
      sum = sum - num_ports;
    end
    return port_idx_width'(sum);
  endfunction

  // high prio requests hide the low prio ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // first requester at or after the pointer
  always_comb begin
    found       = 1'b0;
    grant_idx_o = ptr_q;
    for (int unsigned k = 0; k < num_ports; k++) begin
      if (!found && req_masked[wrap(ptr_q, k)]) begin
        found       = 1'b1;
        grant_idx_o = wrap(ptr_q, k);
      end
    end
  end

  // a refill owns the arrays this cycle
  assign grant_valid_o = found & ~stall_i;

  always_comb begin
    rd_ack_o = '0;
    if (grant_valid_o) begin
      rd_ack_o[grant_idx_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (grant_valid_o) begin
      ptr_q <= wrap(grant_idx_o, 1);
    end
  end

  // a port granted last cycle yields to every other waiting requester
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_o) &&
    !(grant_valid_o && $past(grant_valid_o) && (rd_ack_o == $past(rd_ack_o)) &&
      ((req_masked & ~rd_ack_o) != '0)));

endmodule

// File: mem_array/data_banks.sv
`timescale 1ns/1ps

module data_banks (
  input logic   clk_i,
  bank_if.array bank
);

  localparam int unsigned num_bytes = dcache_pkg::word_width / 8;

  // bank k holds word k of every line, all ways side by side
  for (genvar k = 0; k < dcache_pkg::num_banks; k++) begin : gen_bank
    dcache_pkg::word_t mem_q [dcache_pkg::num_sets][dcache_pkg::num_ways];
    dcache_pkg::word_t [dcache_pkg::num_ways-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank.bank_req[k]) begin
        if (bank.bank_we[k]) begin
          for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            for (int b = 0; b < num_bytes; b++) begin
              if (bank.bank_be[k][w][b]) begin
                mem_q[bank.bank_idx[k]][w][8*b +: 8] <= bank.bank_wdata[k][w][8*b +: 8];
              end
            end
          end
        end else begin
          // read port, output held until the next read
          for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            rdata_q[w] <= mem_q[bank.bank_idx[k]][w];
          end
        end
      end
    end

    assign bank.bank_rdata[k] = rdata_q;
  end

endmodule

// File: mem_array/tag_array.sv
`timescale 1ns/1ps

module tag_array (
  input logic  clk_i,
  input logic  rst_ni,
  tag_if.array tags
);

  for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : gen_way
    dcache_pkg::tag_t                tag_mem [dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] vld_q;
    dcache_pkg::tag_t                tag_rd_q;
    logic                            vld_rd_q;
    logic                            wr_en;
    logic                            rd_en;

    assign wr_en = tags.tag_req[w] & tags.tag_we;
    assign rd_en = tags.tag_req[w] & ~tags.tag_we;

    // tag storage
    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        tag_mem[tags.tag_addr] <= tags.tag_wtag;
      end
      if (rd_en) begin
        tag_rd_q <= tag_mem[tags.tag_addr];
      end
    end

    // valid bits start cleared so untouched sets miss
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q    <= '0;
        vld_rd_q <= 1'b0;
      end else begin
        if (wr_en) begin
          vld_q[tags.tag_addr] <= tags.tag_wvld[w];
        end
        if (rd_en) begin
          vld_rd_q <= vld_q[tags.tag_addr];
        end
      end
    end

    assign tags.tag_rdata[w] = tag_rd_q;
    assign tags.vld_rdata[w] = vld_rd_q;
  end

endmodule

// File: sources.f
common/dcache_pkg.sv
common/bank_if.sv
common/tag_if.sv
logic/read_arbiter.sv
logic/bank_ctrl.sv
logic/hit_select.sv
mem_array/data_banks.sv
mem_array/tag_array.sv
logic/dcache_mem.sv
verif/tb_dcache_mem.sv

// File: verif/dcache_stim.txt
// op 1 refill: we tag idx vld w0 w1 w2 w3 | op 2 read: port idx off tag ack hit vld data
// op 3 write: way idx off data be rd_en rd_off ack | op 4 arbiter: req prio ack, rest zero
1 2 a5 5 2 11111111 22222222 33333333 44444444
2 0 5 0 a5 1 2 2 11111111
2 1 5 4 a5 2 2 2 22222222
2 2 5 8 a5 4 2 2 33333333
2 0 5 c a5 1 2 2 44444444
2 1 5 0 5a 2 0 2 0
2 2 9 0 a5 4 0 0 0
3 2 5 4 aabbccdd 5 0 0 1
2 0 5 4 a5 1 2 2 22bb22dd
3 2 5 8 12345678 f 1 8 0
3 2 5 8 12345678 f 1 0 1
2 1 5 8 a5 2 2 2 12345678
1 1 3c 5 1 55555555 66666666 77777777 88888888
2 2 5 4 3c 4 1 3 66666666
4 7 5 1 0 0 0 0 0
4 7 5 4 0 0 0 0 0
4 7 5 1 0 0 0 0 0
4 7 5 4 0 0 0 0 0
4 2 5 2 0 0 0 0 0
4 7 0 4 0 0 0 0 0

// File: verif/tb_dcache_mem.sv
`timescale 1ns/1ps

module tb_dcache_mem;

  localparam int unsigned num_ports = 3;
  localparam int unsigned rec_len   = 9;
  localparam int unsigned max_recs  = 64;

  logic                             clk_i;
  logic                             rst_ni;
  dcache_pkg::tag_t [num_ports-1:0] rd_tag_i;
  dcache_pkg::idx_t [num_ports-1:0] rd_idx_i;
  dcache_pkg::off_t [num_ports-1:0] rd_off_i;
  logic [num_ports-1:0]             rd_req_i;
  logic [num_ports-1:0]             rd_prio_i;
  logic [num_ports-1:0]             rd_ack_o;
  dcache_pkg::way_vec_t             rd_vld_bits_o;
  dcache_pkg::way_vec_t             rd_hit_oh_o;
  dcache_pkg::word_t                rd_data_o;
  logic                             wr_cl_vld_i;
  dcache_pkg::way_vec_t             wr_cl_we_i;
  dcache_pkg::tag_t                 wr_cl_tag_i;
  dcache_pkg::idx_t                 wr_cl_idx_i;
  dcache_pkg::line_t                wr_cl_data_i;
  dcache_pkg::line_be_t             wr_cl_be_i;
  dcache_pkg::way_vec_t             wr_vld_bits_i;
  dcache_pkg::way_vec_t             wr_req_i;
  logic                             wr_ack_o;
  dcache_pkg::idx_t                 wr_idx_i;
  dcache_pkg::off_t                 wr_off_i;
  dcache_pkg::word_t                wr_data_i;
  dcache_pkg::be_t                  wr_be_i;

  // reference model of the arrays and the round-robin pointer
  dcache_pkg::tag_t  model_tag  [dcache_pkg::num_sets][dcache_pkg::num_ways];
  logic              model_vld  [dcache_pkg::num_sets][dcache_pkg::num_ways];
  dcache_pkg::word_t model_data [dcache_pkg::num_sets][dcache_pkg::num_ways][dcache_pkg::num_banks];
  int unsigned       rr_ptr;

  logic [31:0] stim [rec_len*max_recs];
  int unsigned num_ops;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 1000;

  dcache_mem #(
    .num_ports (num_ports)
  ) uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_tag_i      (rd_tag_i),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_ack_o      (rd_ack_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_data_i  (wr_cl_data_i),
    .wr_cl_be_i    (wr_cl_be_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_req_i      (wr_req_i),
    .wr_ack_o      (wr_ack_o),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .wr_data_i     (wr_data_i),
    .wr_be_i       (wr_be_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // reporting and compares
  ////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      stop_run($sformatf("timeout, run went past %0d cycles", cycle_limit));
    end
  end

  task automatic check_ack(input logic [num_ports-1:0] got, input logic [num_ports-1:0] exp,
                           input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_hit(input dcache_pkg::way_vec_t got, input dcache_pkg::way_vec_t exp,
                           input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_word(input dcache_pkg::word_t got, input dcache_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // the stim file's own expectation has to match the model
  task automatic expect_agrees(input logic [31:0] from_file, input logic [31:0] from_model,
                               input string what);
    if (from_file !== from_model) begin
      stop_run($sformatf("stim file expects %h for %s but the model gives %h",
                         from_file, what, from_model));
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // high prio requests hide low prio ones before the round robin search
  function automatic logic [num_ports-1:0] model_grant(input logic [num_ports-1:0] req,
                                                       input logic [num_ports-1:0] prio);
    logic [num_ports-1:0] cand;
    logic [num_ports-1:0] ack;
    int unsigned          p;
    ack  = '0;
    cand = ((req & prio) != '0) ? (req & prio) : req;
    for (int unsigned n = 0; n < num_ports; n++) begin
      p = (rr_ptr + n) % num_ports;
      if (ack == '0 && cand[p]) begin
        ack[p] = 1'b1;
      end
    end
    return ack;
  endfunction

  task automatic advance_ptr(input logic [num_ports-1:0] ack);
    for (int unsigned p = 0; p < num_ports; p++) begin
      if (ack[p]) begin
        rr_ptr = (p + 1) % num_ports;
      end
    end
  endtask

  ////////////////////
  // operations
  ////////////////////

  task automatic idle_inputs();
    rd_tag_i      = '0;
    rd_idx_i      = '0;
    rd_off_i      = '0;
    rd_req_i      = '0;
    rd_prio_i     = '0;
    wr_cl_vld_i   = 1'b0;
    wr_cl_we_i    = '0;
    wr_cl_tag_i   = '0;
    wr_cl_idx_i   = '0;
    wr_cl_data_i  = '0;
    wr_cl_be_i    = '0;
    wr_vld_bits_i = '0;
    wr_req_i      = '0;
    wr_idx_i      = '0;
    wr_off_i      = '0;
    wr_data_i     = '0;
    wr_be_i       = '0;
  endtask

  // full-line refill while all ports request
  task automatic refill_line(input int unsigned b);
    dcache_pkg::idx_t idx;
    idx = dcache_pkg::idx_t'(stim[b+3]);
    @(negedge clk_i);
    idle_inputs();
    wr_cl_vld_i   = 1'b1;
    wr_cl_we_i    = dcache_pkg::way_vec_t'(stim[b+1]);
    wr_cl_tag_i   = dcache_pkg::tag_t'(stim[b+2]);
    wr_cl_idx_i   = idx;
    wr_vld_bits_i = dcache_pkg::way_vec_t'(stim[b+4]);
    wr_cl_be_i    = '1;
    for (int k = 0; k < dcache_pkg::num_banks; k++) begin
      wr_cl_data_i[k*32 +: 32] = stim[b+5+k];
    end
    rd_req_i  = '1;
    rd_prio_i = '1;
    #10;
    check_ack(rd_ack_o, '0, "read grant during refill");
    for (int w = 0; w < dcache_pkg::num_ways; w++) begin
      if (wr_cl_we_i[w]) begin
        model_tag[idx][w] = wr_cl_tag_i;
        model_vld[idx][w] = wr_vld_bits_i[w];
        for (int k = 0; k < dcache_pkg::num_banks; k++) begin
          model_data[idx][w][k] = stim[b+5+k];
        end
      end
    end
  endtask

  // single-port read with the grant in one cycle and the lookup result in the next
  task automatic lookup_read(input int unsigned b);
    int unsigned          port;
    dcache_pkg::idx_t     idx;
    dcache_pkg::off_t     off;
    dcache_pkg::tag_t     tag;
    logic [num_ports-1:0] req;
    logic [num_ports-1:0] ack_exp;
    dcache_pkg::way_vec_t hit_exp;
    dcache_pkg::way_vec_t vld_exp;
    dcache_pkg::word_t    data_exp;
    port     = stim[b+1];
    idx      = dcache_pkg::idx_t'(stim[b+2]);
    off      = dcache_pkg::off_t'(stim[b+3]);
    tag      = dcache_pkg::tag_t'(stim[b+4]);
    req      = '0;
    req[port] = 1'b1;
    ack_exp  = model_grant(req, '0);
    advance_ptr(ack_exp);
    data_exp = model_data[idx][0][off[3:2]];
    for (int w = 0; w < dcache_pkg::num_ways; w++) begin
      vld_exp[w] = model_vld[idx][w];
      hit_exp[w] = model_vld[idx][w] && (model_tag[idx][w] == tag);
      if (hit_exp[w]) begin
        data_exp = model_data[idx][w][off[3:2]];
      end
    end
    expect_agrees(stim[b+5], 32'(ack_exp), "read grant");
    expect_agrees(stim[b+6], 32'(hit_exp), "hit vector");
    expect_agrees(stim[b+7], 32'(vld_exp), "valid bits");
    if (hit_exp != '0) begin
      expect_agrees(stim[b+8], data_exp, "read data");
    end
    @(negedge clk_i);
    idle_inputs();
    rd_req_i[port] = 1'b1;
    rd_idx_i[port] = idx;
    rd_off_i[port] = off;
    #10;
    check_ack(rd_ack_o, ack_exp, "read grant");
    @(negedge clk_i);
    idle_inputs();
    rd_tag_i[port] = tag;
    #10;
    check_hit(rd_hit_oh_o, hit_exp, "hit vector");
    check_hit(rd_vld_bits_o, vld_exp, "valid bits");
    if (hit_exp != '0) begin
      check_word(rd_data_o, data_exp, "read data");
    end
  endtask

  // word write optionally beside a read of port 0 at the same set
  task automatic write_word(input int unsigned b);
    dcache_pkg::way_vec_t way;
    dcache_pkg::idx_t     idx;
    dcache_pkg::off_t     off;
    dcache_pkg::off_t     rd_off;
    logic                 with_read;
    logic [num_ports-1:0] rd_ack_exp;
    logic                 ack_exp;
    way        = dcache_pkg::way_vec_t'(stim[b+1]);
    idx        = dcache_pkg::idx_t'(stim[b+2]);
    off        = dcache_pkg::off_t'(stim[b+3]);
    with_read  = stim[b+6][0];
    rd_off     = dcache_pkg::off_t'(stim[b+7]);
    rd_ack_exp = with_read ? model_grant(num_ports'(1), '0) : '0;
    advance_ptr(rd_ack_exp);
    ack_exp    = !(with_read && (rd_off[3:2] == off[3:2]));
    expect_agrees(stim[b+8], 32'(ack_exp), "word write ack");
    @(negedge clk_i);
    idle_inputs();
    wr_req_i  = way;
    wr_idx_i  = idx;
    wr_off_i  = off;
    wr_data_i = stim[b+4];
    wr_be_i   = dcache_pkg::be_t'(stim[b+5]);
    if (with_read) begin
      rd_req_i[0] = 1'b1;
      rd_idx_i[0] = idx;
      rd_off_i[0] = rd_off;
    end
    #10;
    check_flag(wr_ack_o, ack_exp, "word write ack");
    check_ack(rd_ack_o, rd_ack_exp, "read grant beside word write");
    if (ack_exp) begin
      for (int w = 0; w < dcache_pkg::num_ways; w++) begin
        for (int y = 0; y < 4; y++) begin
          if (way[w] && wr_be_i[y]) begin
            model_data[idx][w][off[3:2]][8*y +: 8] = wr_data_i[8*y +: 8];
          end
        end
      end
    end
  endtask

  task automatic arbitrate_ports(input int unsigned b);
    logic [num_ports-1:0] req;
    logic [num_ports-1:0] prio;
    logic [num_ports-1:0] ack_exp;
    req     = stim[b+1][num_ports-1:0];
    prio    = stim[b+2][num_ports-1:0];
    ack_exp = model_grant(req, prio);
    advance_ptr(ack_exp);
    expect_agrees(stim[b+3], 32'(ack_exp), "arbiter grant");
    @(negedge clk_i);
    idle_inputs();
    rd_req_i  = req;
    rd_prio_i = prio;
    #10;
    check_ack(rd_ack_o, ack_exp, "arbiter grant");
  endtask

  initial begin
    rst_ni = 1'b0;
    idle_inputs();
    for (int unsigned i = 0; i < rec_len*max_recs; i++) begin
      stim[i] = '0;
    end
    $readmemh("verif/dcache_stim.txt", stim);
    num_ops = 0;
    while (num_ops < max_recs && stim[num_ops*rec_len] != 0) begin
      num_ops++;
    end
    if (num_ops == 0) begin
      stop_run("stimulus file holds no operations");
    end
    cycle_limit = 4*num_ops + 20;
    rr_ptr = 0;
    for (int s = 0; s < dcache_pkg::num_sets; s++) begin
      for (int w = 0; w < dcache_pkg::num_ways; w++) begin
        model_tag[s][w] = '0;
        model_vld[s][w] = 1'b0;
        for (int k = 0; k < dcache_pkg::num_banks; k++) begin
          model_data[s][w][k] = '0;
        end
      end
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #10;
    check_ack(rd_ack_o, '0, "read grant after reset");
    check_flag(wr_ack_o, 1'b0, "word write ack after reset");
    check_hit(rd_hit_oh_o, '0, "hit vector after reset");

    for (int unsigned n = 0; n < num_ops; n++) begin
      case (stim[n*rec_len])
        1: refill_line(n*rec_len);
        2: lookup_read(n*rec_len);
        3: write_word(n*rec_len);
        4: arbitrate_ports(n*rec_len);
        default: stop_run($sformatf("unknown operation code on stimulus line %0d", n));
      endcase
    end
    @(negedge clk_i);
    idle_inputs();

    $display("All checks passed");
    $finish;
  end

endmodule
